/* src.f */
hdl/rv_isa_pkg.sv
hdl/axi_lite_pkg.sv
hdl/register_file.sv
hdl/inst_queue.sv
hdl/fetch_unit.sv
hdl/exec_unit.sv
hdl/core_top.sv
bench/core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the core testbench with Verilator.

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f src.f -o core_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/core_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" "$log"; then
	echo "Simulation reported failure"
	exit 1
fi
if ! grep -q "\*\*\* TEST PASSED \*\*\*" "$log"; then
	echo "Simulation ended without a result line"
	exit 1
fi
exit 0

/* bench/core_tb.sv */
`timescale 1ns/1ps

module core_tb import rv_isa_pkg::*, axi_lite_pkg::*; ();

	localparam logic [31:0] start_pc = 32'h0000_0200;
	localparam int depth = 4;
	localparam int mem_words = 32;

	logic clock;
	logic reset = 1'b1;
	logic arvalid;
	logic [31:0] araddr;
	logic [2:0] arprot;
	logic arready = 1'b0;
	logic rvalid = 1'b0;
	logic [31:0] rdata = '0;
	resp_e rresp = RESP_OKAY;
	logic rready;
	logic retire_valid;
	logic [3:0] retire_rd;
	logic [31:0] retire_data;
	logic [31:0] retire_pc;
	logic halted;
	logic illegal_fault;
	logic fetch_fault;

	integer seed = 12;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int limit = 1000;
	int mem_state = 0;
	int wait_cnt = 0;
	int word_idx = 0;
	int prog_len = 0;
	int fault_idx = -1;
	logic [31:0] next_addr = '0;
	logic drained = 1'b0;
	logic exp_halt;
	logic exp_illegal;
	logic exp_ff;
	logic [31:0] prog [mem_words];
	logic [31:0] model_regs [16];
	logic [31:0] exp_pc [$];
	logic [31:0] exp_rd [$];
	logic [31:0] exp_data [$];

	core_top #(
		.reset_pc(start_pc),
		.queue_depth(depth)
	) uut (
		.clock(clock),
		.reset(reset),
		.arvalid(arvalid),
		.araddr(araddr),
		.arprot(arprot),
		.arready(arready),
		.rvalid(rvalid),
		.rdata(rdata),
		.rresp(rresp),
		.rready(rready),
		.retire_valid(retire_valid),
		.retire_rd(retire_rd),
		.retire_data(retire_data),
		.retire_pc(retire_pc),
		.halted(halted),
		.illegal_fault(illegal_fault),
		.fetch_fault(fetch_fault)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	function automatic logic [31:0] enc_i(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
			logic [11:0] imm);
		return {imm, rs1, f3, rd, OP_IMM};
	endfunction

	function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
			logic [4:0] rs1, logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, OP_REG};
	endfunction

	function automatic logic [31:0] enc_lui(logic [4:0] rd, logic [19:0] imm);
		return {imm, rd, OP_LUI};
	endfunction

	// Filler is ADDI x15 with the word index, never meant to execute.
	function automatic logic [31:0] pad_word(input int idx);
		return enc_i(F3_ADD, 5'd15, 5'd15, idx[11:0]);
	endfunction

	function automatic logic [31:0] word_at(input int idx);
		if (idx >= 0 && idx < mem_words) begin
			return prog[idx];
		end
		return pad_word(idx);
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
		checks++;
		assert (got === want) else begin
			errors++;
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, want);
		end
	endtask

	task automatic clear_program();
		prog_len = 0;
		for (int i = 0; i < mem_words; i++) begin
			prog[i] = pad_word(i);
		end
	endtask

	task automatic put(input logic [31:0] word);
		prog[prog_len] = word;
		prog_len++;
	endtask

	task automatic add_random(input int count);
		logic [2:0] f3;
		logic [1:0] sel;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		int kind;
		for (int i = 0; i < count; i++) begin
			kind = $random(seed) & 3;
			sel = 2'($random(seed));
			rd = {1'b0, 4'($random(seed))};
			rs1 = {1'b0, 4'($random(seed))};
			rs2 = {1'b0, 4'($random(seed))};
			f3 = (sel == 0) ? F3_ADD : (sel == 1) ? F3_XOR : (sel == 2) ? F3_OR : F3_AND;
			if (kind == 0) begin
				put(enc_lui(rd, 20'($random(seed))));
			end else if (kind == 1) begin
				put(enc_i(f3, rd, rs1, 12'($random(seed))));
			end else if (kind == 2 || f3 != F3_ADD) begin
				put(enc_r(F7_BASE, f3, rd, rs1, rs2));
			end else begin
				put(enc_r(F7_SUB, f3, rd, rs1, rs2));
			end
		end
	endtask

	// Reference model walks the image in order until it stops.
	task automatic build_expected();
		logic [31:0] w;
		logic [31:0] b;
		logic [31:0] res;
		logic ok;
		logic stop;
		alu_op_e op;
		exp_pc.delete();
		exp_rd.delete();
		exp_data.delete();
		exp_halt = 1'b0;
		exp_illegal = 1'b0;
		exp_ff = 1'b0;
		stop = 1'b0;
		for (int r = 0; r < 16; r++) begin
			model_regs[r] = '0;
		end
		for (int i = 0; i < mem_words && !stop; i++) begin
			w = prog[i];
			ok = !w[11]; // rd below 16.
			op = ALU_ADD;
			b = {{20{w[31]}}, w[31:20]};
			res = '0;
			if (i == fault_idx) begin
				exp_ff = 1'b1;
				stop = 1'b1;
			end else if (w == ebreak_word) begin
				exp_halt = 1'b1;
				stop = 1'b1;
			end else begin
				case (w[6:0])
					OP_LUI: begin
						op = ALU_PASS;
						b = {w[31:12], 12'h000};
					end
					OP_IMM, OP_REG: begin
						ok = ok && !w[19];
						case (w[14:12])
							F3_ADD: op = ALU_ADD;
							F3_XOR: op = ALU_XOR;
							F3_OR: op = ALU_OR;
							F3_AND: op = ALU_AND;
							default: ok = 1'b0;
						endcase
						if (w[6:0] == OP_REG) begin
							ok = ok && !w[24];
							b = model_regs[w[23:20]];
							if (w[31:25] == F7_SUB && w[14:12] == F3_ADD) begin
								op = ALU_SUB;
							end else if (w[31:25] != F7_BASE) begin
								ok = 1'b0;
							end
						end
					end
					default: ok = 1'b0;
				endcase
				case (op)
					ALU_ADD: res = model_regs[w[18:15]] + b;
					ALU_SUB: res = model_regs[w[18:15]] - b;
					ALU_XOR: res = model_regs[w[18:15]] ^ b;
					ALU_OR: res = model_regs[w[18:15]] | b;
					ALU_AND: res = model_regs[w[18:15]] & b;
					default: res = b;
				endcase
				if (!ok) begin
					exp_illegal = 1'b1;
					exp_halt = 1'b1;
					stop = 1'b1;
				end else begin
					exp_pc.push_back(start_pc + 32'(4 * i));
					exp_rd.push_back({28'h0, w[10:7]});
					exp_data.push_back(res);
					if (w[10:7] != 4'd0) begin
						model_regs[w[10:7]] = res;
					end
				end
			end
		end
	endtask

	task automatic run_program(input int fault);
		@(negedge clock);
		fault_idx = fault;
		limit = 40 * prog_len + 200;
		build_expected();
		@(posedge clock);
		reset <= 1'b1;
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		while (!(exp_pc.size() == 0 && drained)) begin
			@(posedge clock);
		end
		repeat (20) @(negedge clock); // Room for a stray retire.
		compare("halted", halted, exp_halt);
		compare("illegal_fault", illegal_fault, exp_illegal);
		compare("fetch_fault", fetch_fault, exp_ff);
	endtask

	// AXI4-Lite read slave with random AR and R delays.
	always @(posedge clock) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rdata <= '0;
			rresp <= RESP_OKAY;
			mem_state <= 0;
			wait_cnt <= 0;
			next_addr <= start_pc;
		end else begin
			case (mem_state)
				0: begin
					if (arvalid && wait_cnt == 0) begin
						arready <= 1'b1;
						mem_state <= 1;
					end else if (arvalid) begin
						wait_cnt <= wait_cnt - 1;
					end
				end
				1: begin
					if (arvalid) begin
						arready <= 1'b0; // AR handshake on this edge.
						word_idx <= int'((araddr - start_pc) >> 2);
						wait_cnt <= $random(seed) & 3;
						mem_state <= 2;
					end
				end
				2: begin
					if (wait_cnt == 0) begin
						rvalid <= 1'b1;
						rdata <= word_at(word_idx);
						rresp <= (word_idx == fault_idx) ? RESP_SLVERR : RESP_OKAY;
						mem_state <= 3;
					end else begin
						wait_cnt <= wait_cnt - 1;
					end
				end
				default: begin
					if (rready) begin
						rvalid <= 1'b0; // R handshake on this edge.
						if (rresp == RESP_OKAY) begin
							next_addr <= next_addr + 32'd4;
						end
						wait_cnt <= $random(seed) & 3;
						mem_state <= 0;
					end
				end
			endcase
		end
	end

	always @(negedge clock) begin
		if (reset) begin
			drained = 1'b0;
		end else begin
			if (retire_valid) begin
				assert (exp_pc.size() != 0) else begin
					errors++;
					$display("Retirement of pc %h came when none was expected", retire_pc);
				end
				if (exp_pc.size() != 0) begin
					compare("retire_pc", retire_pc, exp_pc.pop_front());
					compare("retire_rd", {28'h0, retire_rd}, exp_rd.pop_front());
					compare("retire_data", retire_data, exp_data.pop_front());
				end
			end
			if (arvalid) begin
				compare("arprot", {29'h0, arprot}, 32'h0);
			end
			if (mem_state == 1) begin
				compare("araddr", araddr, next_addr);
			end
			if (mem_state == 2 || mem_state == 3) begin
				compare("rready", {31'h0, rready}, 32'h1);
			end
			if (drained) begin
				compare("arvalid", {31'h0, arvalid}, 32'h0);
			end
			if ((halted || fetch_fault) && !arvalid && mem_state == 0) begin
				drained = 1'b1;
			end
		end
	end

	always @(posedge clock) begin
		if (reset) begin
			cycles <= 0;
		end else begin
			cycles <= cycles + 1;
			if (cycles >= limit) begin
				$display("Timeout: the program did not finish within %0d cycles", limit);
				$display("Checks: %0d, errors: %0d", checks, errors);
				$display("*** TEST FAILED ***");
				$finish;
			end
		end
	end

	initial begin
		clear_program();
		put(enc_lui(5'd1, 20'h12345));
		put(enc_i(F3_ADD, 5'd2, 5'd1, 12'h678));
		put(enc_i(F3_XOR, 5'd3, 5'd2, 12'hfff));
		put(enc_i(F3_OR, 5'd4, 5'd0, 12'h0f0));
		put(enc_i(F3_AND, 5'd5, 5'd3, 12'h7ff));
		put(enc_i(F3_ADD, 5'd6, 5'd0, 12'h800));
		put(ebreak_word);
		run_program(-1);

		clear_program();
		put(enc_i(F3_ADD, 5'd1, 5'd0, 12'd100));
		put(enc_i(F3_ADD, 5'd2, 5'd0, 12'hfdb));
		put(enc_r(F7_BASE, F3_ADD, 5'd3, 5'd1, 5'd2));
		put(enc_r(F7_SUB, F3_ADD, 5'd4, 5'd1, 5'd2));
		put(enc_r(F7_SUB, F3_ADD, 5'd5, 5'd2, 5'd1));
		put(enc_r(F7_BASE, F3_XOR, 5'd6, 5'd3, 5'd4));
		put(enc_r(F7_BASE, F3_OR, 5'd7, 5'd6, 5'd5));
		put(enc_r(F7_BASE, F3_AND, 5'd8, 5'd7, 5'd1));
		put(enc_r(F7_BASE, F3_ADD, 5'd3, 5'd3, 5'd3));
		put(enc_r(F7_SUB, F3_ADD, 5'd3, 5'd3, 5'd1));
		put(enc_i(F3_ADD, 5'd0, 5'd1, 12'd55)); // Write to x0.
		put(enc_r(F7_BASE, F3_ADD, 5'd10, 5'd0, 5'd1));
		put(enc_r(F7_BASE, F3_OR, 5'd11, 5'd0, 5'd0));
		put(ebreak_word);
		run_program(-1);

		clear_program();
		add_random(24);
		put(ebreak_word);
		run_program(-1);

		clear_program();
		put(enc_i(F3_ADD, 5'd1, 5'd0, 12'd1));
		put(32'h0000_0007); // Unknown major opcode.
		put(enc_i(F3_ADD, 5'd2, 5'd0, 12'd2));
		put(ebreak_word);
		run_program(-1);

		clear_program();
		put(enc_i(F3_ADD, 5'd1, 5'd0, 12'd7));
		put(enc_i(F3_ADD, 5'd16, 5'd1, 12'd3));
		put(enc_i(F3_ADD, 5'd2, 5'd0, 12'd2));
		put(ebreak_word);
		run_program(-1);

		clear_program();
		put(enc_i(F3_ADD, 5'd1, 5'd0, 12'd11));
		put(enc_i(F3_ADD, 5'd2, 5'd0, 12'd22));
		put(enc_r(F7_BASE, F3_ADD, 5'd3, 5'd1, 5'd2));
		put(enc_r(F7_BASE, F3_XOR, 5'd4, 5'd3, 5'd1));
		put(enc_i(F3_OR, 5'd5, 5'd4, 12'h100));
		put(enc_i(F3_ADD, 5'd6, 5'd0, 12'd66)); // SLVERR here.
		put(enc_i(F3_ADD, 5'd7, 5'd0, 12'd77));
		put(ebreak_word);
		run_program(5);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* hdl/core_top.sv */
`timescale 1ns/1ps

module core_top import rv_isa_pkg::*, axi_lite_pkg::*; #(
	parameter logic [addr_width-1:0] reset_pc = '0,
	parameter int queue_depth = 4
) (
	input  logic                     clock,
	input  logic                     reset,
	output logic                     arvalid,
	output logic [addr_width-1:0]    araddr,
	output logic [prot_width-1:0]    arprot,
	input  logic                     arready,
	input  logic                     rvalid,
	input  logic [xlen-1:0]          rdata,
	input  resp_e                    rresp,
	output logic                     rready,
	output logic                     retire_valid,
	output logic [reg_idx_width-1:0] retire_rd,
	output logic [xlen-1:0]          retire_data,
	output logic [xlen-1:0]          retire_pc,
	output logic                     halted,
	output logic                     illegal_fault,
	output logic                     fetch_fault
);

	logic push;
	logic [xlen-1:0] push_inst;
	logic [xlen-1:0] push_pc;
	logic full;
	logic empty;
	logic pop;
	logic [xlen-1:0] head_inst;
	logic [xlen-1:0] head_pc;

	fetch_unit #(
		.reset_pc(reset_pc)
	) u_fetch (
		.clock(clock),
		.reset(reset),
		.halted(halted),
		.full(full),
		.arvalid(arvalid),
		.araddr(araddr),
		.arprot(arprot),
		.arready(arready),
		.rvalid(rvalid),
		.rdata(rdata),
		.rresp(rresp),
		.rready(rready),
		.push(push),
		.push_inst(push_inst),
		.push_pc(push_pc),
		.fetch_fault(fetch_fault)
	);

	inst_queue #(
		.queue_depth(queue_depth)
	) u_queue (
		.clock(clock),
		.reset(reset),
		.push(push),
		.push_inst(push_inst),
		.push_pc(push_pc),
		.pop(pop),
		.full(full),
		.empty(empty),
		.head_inst(head_inst),
		.head_pc(head_pc)
	);

	exec_unit u_exec (
		.clock(clock),
		.reset(reset),
		.empty(empty),
		.head_inst(head_inst),
		.head_pc(head_pc),
		.pop(pop),
		.halted(halted),
		.illegal_fault(illegal_fault),
		.retire_valid(retire_valid),
		.retire_rd(retire_rd),
		.retire_data(retire_data),
		.retire_pc(retire_pc)
	);

endmodule

/* hdl/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit import rv_isa_pkg::*; (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     empty,
	input  logic [xlen-1:0]          head_inst,
	input  logic [xlen-1:0]          head_pc,
	output logic                     pop,
	output logic                     halted,
	output logic                     illegal_fault,
	output logic                     retire_valid,
	output logic [reg_idx_width-1:0] retire_rd,
	output logic [xlen-1:0]          retire_data,
	output logic [xlen-1:0]          retire_pc
);

	logic [4:0] rd;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_u;
	logic [xlen-1:0] src1;
	logic [xlen-1:0] src2;
	logic [xlen-1:0] operand_b;
	logic [xlen-1:0] result;
	alu_op_e alu_op;
	logic legal;
	logic is_ebreak;
	logic use_rs1;
	logic use_rs2;
	logic fire;
	logic wen;

	assign rd = head_inst[11:7];
	assign funct3 = head_inst[14:12];
	assign rs1 = head_inst[19:15];
	assign rs2 = head_inst[24:20];
	assign funct7 = head_inst[31:25];
	assign imm_i = {{20{head_inst[31]}}, head_inst[31:20]};
	assign imm_u = {head_inst[31:12], 12'b0};

	always_comb begin
		alu_op = ALU_ADD;
		operand_b = imm_i;
		legal = 1'b1;
		is_ebreak = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		case (head_inst[6:0])
			OP_LUI: begin
				alu_op = ALU_PASS;
				operand_b = imm_u;
			end
			OP_IMM: begin
				use_rs1 = 1'b1;
				case (funct3)
					F3_ADD: alu_op = ALU_ADD;
					F3_XOR: alu_op = ALU_XOR;
					F3_OR: alu_op = ALU_OR;
					F3_AND: alu_op = ALU_AND;
					default: legal = 1'b0; // Shifts and compares.
				endcase
			end
			OP_REG: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				operand_b = src2;
				if (funct7 == F7_SUB && funct3 == F3_ADD) begin
					alu_op = ALU_SUB;
				end else if (funct7 != F7_BASE) begin
					legal = 1'b0;
				end else begin
					case (funct3)
						F3_ADD: alu_op = ALU_ADD;
						F3_XOR: alu_op = ALU_XOR;
						F3_OR: alu_op = ALU_OR;
						F3_AND: alu_op = ALU_AND;
						default: legal = 1'b0;
					endcase
				end
			end
			OP_SYSTEM: begin
				is_ebreak = (head_inst == ebreak_word);
				legal = is_ebreak;
			end
			default: legal = 1'b0;
		endcase
		// No x16 to x31 in RV32E.
		if (rd[4] || (use_rs1 && rs1[4]) || (use_rs2 && rs2[4])) begin
			legal = 1'b0;
		end
	end

	always_comb begin
		case (alu_op)
			ALU_ADD: result = src1 + operand_b;
			ALU_SUB: result = src1 - operand_b;
			ALU_XOR: result = src1 ^ operand_b;
			ALU_OR: result = src1 | operand_b;
			ALU_AND: result = src1 & operand_b;
			default: result = operand_b;
		endcase
	end

	assign fire = !empty && !halted;
	assign pop = fire;
	assign wen = fire && legal && !is_ebreak;

	register_file u_regs (
		.clock(clock),
		.reset(reset),
		.raddr1(rs1[reg_idx_width-1:0]),
		.raddr2(rs2[reg_idx_width-1:0]),
		.rdata1(src1),
		.rdata2(src2),
		.wen(wen),
		.waddr(rd[reg_idx_width-1:0]),
		.wdata(result)
	);

	always_ff @(posedge clock) begin
		if (reset) begin
			halted <= 1'b0;
			illegal_fault <= 1'b0;
			retire_valid <= 1'b0;
		end else begin
			retire_valid <= wen;
			if (fire && !legal) begin
				illegal_fault <= 1'b1;
				halted <= 1'b1;
			end else if (fire && is_ebreak) begin
				halted <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (wen) begin
			retire_rd <= rd[reg_idx_width-1:0];
			retire_data <= result;
			retire_pc <= head_pc;
		end
	end

endmodule

/* hdl/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit import rv_isa_pkg::*, axi_lite_pkg::*; #(
	parameter logic [addr_width-1:0] reset_pc = '0
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  halted,
	input  logic                  full,
	output logic                  arvalid,
	output logic [addr_width-1:0] araddr,
	output logic [prot_width-1:0] arprot,
	input  logic                  arready,
	input  logic                  rvalid,
	input  logic [xlen-1:0]       rdata,
	input  resp_e                 rresp,
	output logic                  rready,
	output logic                  push,
	output logic [xlen-1:0]       push_inst,
	output logic [xlen-1:0]       push_pc,
	output logic                  fetch_fault
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ADDR,
		ST_DATA,
		ST_STOP
	} state_e;

	state_e state;
	logic [addr_width-1:0] pc;

	assign arvalid = (state == ST_ADDR);
	assign araddr = pc;
	assign arprot = '0; // Unprivileged, secure, data.
	assign rready = (state == ST_DATA);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ST_IDLE;
			pc <= reset_pc;
			push <= 1'b0;
			fetch_fault <= 1'b0;
		end else begin
			push <= 1'b0;
			case (state)
				ST_IDLE: begin
					// A push still in flight counts as an occupied slot.
					if (!full && !push && !halted) begin
						state <= ST_ADDR;
					end
				end
				ST_ADDR: begin
					if (arready) begin
						state <= ST_DATA;
					end
				end
				ST_DATA: begin
					if (rvalid) begin
						if (rresp == RESP_OKAY) begin
							push <= 1'b1;
							pc <= pc + 32'd4;
							state <= ST_IDLE;
						end else begin
							fetch_fault <= 1'b1;
							state <= ST_STOP;
						end
					end
				end
				default: begin
					state <= ST_STOP; // Only reset leaves here.
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == ST_DATA && rvalid) begin
			push_inst <= rdata;
			push_pc <= pc;
		end
	end

endmodule

/* hdl/inst_queue.sv */
`timescale 1ns/1ps

module inst_queue import rv_isa_pkg::*; #(
	parameter int queue_depth = 4
) (
	input  logic            clock,
	input  logic            reset,
	input  logic            push,
	input  logic [xlen-1:0] push_inst,
	input  logic [xlen-1:0] push_pc,
	input  logic            pop,
	output logic            full,
	output logic            empty,
	output logic [xlen-1:0] head_inst,
	output logic [xlen-1:0] head_pc
);

	localparam int idx_width = $clog2(queue_depth);

	logic [xlen-1:0] inst_mem [queue_depth];
	logic [xlen-1:0] pc_mem [queue_depth];
	logic [idx_width:0] wr_ptr;
	logic [idx_width:0] rd_ptr;
	logic do_pop;

	// Extra pointer bit tells a wrapped full queue from an empty one.
	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[idx_width] != rd_ptr[idx_width]) &&
		(wr_ptr[idx_width-1:0] == rd_ptr[idx_width-1:0]);
	assign do_pop = pop && !empty;

	assign head_inst = inst_mem[rd_ptr[idx_width-1:0]];
	assign head_pc = pc_mem[rd_ptr[idx_width-1:0]];

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			inst_mem[wr_ptr[idx_width-1:0]] <= push_inst;
			pc_mem[wr_ptr[idx_width-1:0]] <= push_pc;
		end
	end

endmodule

/* hdl/register_file.sv */
`timescale 1ns/1ps

module register_file import rv_isa_pkg::*; (
	input  logic                     clock,
	input  logic                     reset,
	input  logic [reg_idx_width-1:0] raddr1,
	input  logic [reg_idx_width-1:0] raddr2,
	output logic [xlen-1:0]          rdata1,
	output logic [xlen-1:0]          rdata2,
	input  logic                     wen,
	input  logic [reg_idx_width-1:0] waddr,
	input  logic [xlen-1:0]          wdata
);

	logic [xlen-1:0] regs [reg_count];

	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata; // x0 stays zero.
		end
	end

endmodule

/* hdl/axi_lite_pkg.sv */
package axi_lite_pkg;

	localparam int addr_width = 32;
	localparam int prot_width = 3;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} resp_e;

endpackage

/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

	localparam int xlen = 32;
	localparam int reg_count = 16; // RV32E.
	localparam int reg_idx_width = $clog2(reg_count);

	// Major opcodes of the supported subset.
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011,
		OP_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_PASS // Operand b straight through, for LUI.
	} alu_op_e;

	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_OR  = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_SUB  = 7'b0100000; // Also selects SUB over ADD.

	localparam logic [xlen-1:0] ebreak_word = 32'h0010_0073;

endpackage
